/* Bender.yml */
package:
  name: tiny16

export_include_dirs:
  - design

sources:
  - files:
      - design/tiny16_isa_pkg.sv
      - design/tiny16_bus_pkg.sv
      - design/registers.sv
      - design/alu.sv
      - design/data_bus.sv
      - design/controller.sv
      - design/tiny16.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tiny16_assertions.sv
      - verification/tb_tiny16.sv

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tiny16_consts.svh"

module alu (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire tiny16_isa_pkg::alu_func_e func,
    input  wire  [`TINY16_XLEN-1:0]   op_a,     // destination register
    input  wire  [`TINY16_XLEN-1:0]   op_b,     // source register
    input  wire                       flag_en,
    output logic [`TINY16_XLEN-1:0]   result,
    output tiny16_isa_pkg::flags_t    flags
);

    logic [`TINY16_XLEN:0] sum;  // top bit is carry or borrow
    logic                  carry;
    logic                  ovf;

    always_comb begin
        sum    = '0;
        result = op_a;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (func)
            tiny16_isa_pkg::ADD: begin
                sum    = {1'b0, op_a} + {1'b0, op_b};
                result = sum[`TINY16_XLEN-1:0];
                carry  = sum[`TINY16_XLEN];
                // same operand signs, result sign flipped
                ovf    = (op_a[`TINY16_XLEN-1] == op_b[`TINY16_XLEN-1]) &&
                         (result[`TINY16_XLEN-1] != op_a[`TINY16_XLEN-1]);
            end
            tiny16_isa_pkg::SUB: begin
                sum    = {1'b0, op_a} - {1'b0, op_b};
                result = sum[`TINY16_XLEN-1:0];
                carry  = sum[`TINY16_XLEN];  // borrow
                ovf    = (op_a[`TINY16_XLEN-1] != op_b[`TINY16_XLEN-1]) &&
                         (result[`TINY16_XLEN-1] != op_a[`TINY16_XLEN-1]);
            end
            tiny16_isa_pkg::AND: result = op_a & op_b;
            tiny16_isa_pkg::OR:  result = op_a | op_b;
            tiny16_isa_pkg::XOR: result = op_a ^ op_b;
            tiny16_isa_pkg::SHL: begin
                result = {op_b[`TINY16_XLEN-2:0], 1'b0};
                carry  = op_b[`TINY16_XLEN-1];  // bit shifted out
            end
            tiny16_isa_pkg::SHR: begin
                result = {1'b0, op_b[`TINY16_XLEN-1:1]};
                carry  = op_b[0];
            end
            tiny16_isa_pkg::MOV: result = op_b;
            default:             result = op_a;
        endcase
    end

    // flags only move on ALU instructions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_en) begin
            flags.z <= (result == '0);
            flags.c <= carry;
            flags.n <= result[`TINY16_XLEN-1];
            flags.v <= ovf;
        end
    end

endmodule

`default_nettype wire

/* design/controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tiny16_consts.svh"

module controller (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire  [`TINY16_XLEN-1:0]   bus,
    input  wire tiny16_isa_pkg::flags_t flags,
    input  wire  [`TINY16_XLEN-1:0]   pc,
    input  wire  [`TINY16_XLEN-1:0]   dst_data,
    input  wire  [`TINY16_XLEN-1:0]   src_data,
    output tiny16_bus_pkg::wb_req_t   wb_req,
    input  wire tiny16_bus_pkg::wb_rsp_t wb_rsp,
    output logic [3:0]                src_sel,
    output logic [3:0]                dst_sel,
    output logic                      wr_hi,
    output logic                      wr_lo,
    output logic                      pc_inc,
    output logic                      pc_load,
    output tiny16_isa_pkg::alu_func_e alu_func,
    output logic                      flag_en,
    output tiny16_bus_pkg::bus_src_e  bus_sel,
    output logic [`TINY16_XLEN-1:0]   ctl_data,
    output logic [`TINY16_XLEN-1:0]   mem_data,
    output logic                      out_en,
    output logic                      halted
);

    typedef enum logic [2:0] {
        S_IDLE,    // one cycle out of reset
        S_FETCH,
        S_DECODE,
        S_MEM,     // LD and ST only
        S_EXEC,
        S_HALT
    } state_e;

    state_e                 state;
    state_e                 next_state;
    tiny16_isa_pkg::instr_t ir;
    logic [`TINY16_XLEN-1:0] mem_q;
    logic                   is_mem_op;
    logic [`TINY16_XLEN-1:0] imm_lo;

    assign is_mem_op = (ir.opcode == tiny16_isa_pkg::LD) || (ir.opcode == tiny16_isa_pkg::ST);
    assign imm_lo    = {{(`TINY16_XLEN-8){1'b0}}, ir.operand.imm_form.imm};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:   next_state = S_FETCH;
            S_FETCH:  if (wb_rsp.ack) next_state = S_DECODE;
            S_DECODE: next_state = is_mem_op ? S_MEM : S_EXEC;
            S_MEM:    if (wb_rsp.ack) next_state = S_EXEC;
            S_EXEC: begin
                next_state = (ir.opcode == tiny16_isa_pkg::HALT) ? S_HALT : S_FETCH;
            end
            S_HALT:   next_state = S_HALT;  // only reset leaves
            default:  next_state = S_IDLE;
        endcase
    end

    // instruction word and load data, taken on ack
    always_ff @(posedge clk) begin
        if (state == S_FETCH && wb_rsp.ack) begin
            ir <= tiny16_isa_pkg::instr_t'(wb_rsp.dat);
        end
        if (state == S_MEM && wb_rsp.ack) begin
            mem_q <= wb_rsp.dat;
        end
    end

    assign mem_data = mem_q;
    assign halted   = (state == S_HALT);

    // request follows the state, so it is stable until ack
    always_comb begin
        wb_req = '0;
        case (state)
            S_FETCH: begin
                wb_req.cyc = 1'b1;
                wb_req.stb = 1'b1;
                wb_req.adr = pc;
            end
            S_MEM: begin
                wb_req.cyc = 1'b1;
                wb_req.stb = 1'b1;
                if (ir.opcode == tiny16_isa_pkg::ST) begin
                    wb_req.we  = 1'b1;
                    wb_req.adr = dst_data;
                    wb_req.dat = bus;       // source register on the bus
                end else begin
                    wb_req.adr = src_data;
                end
            end
            default: wb_req = '0;
        endcase
    end

    always_comb begin
        // selects come straight from the register form fields
        src_sel  = ir.operand.reg_form.src;
        dst_sel  = ir.operand.reg_form.dst;
        alu_func = ir.operand.reg_form.alu_func;
        wr_hi    = 1'b0;
        wr_lo    = 1'b0;
        pc_inc   = (state == S_FETCH) && wb_rsp.ack;
        pc_load  = 1'b0;
        flag_en  = 1'b0;
        bus_sel  = tiny16_bus_pkg::NONE;
        ctl_data = '0;
        out_en   = 1'b0;

        if (state == S_MEM && ir.opcode == tiny16_isa_pkg::ST) begin
            bus_sel = tiny16_bus_pkg::REG;  // store data
        end

        if (state == S_EXEC) begin
            case (ir.opcode)
                tiny16_isa_pkg::ALU: begin
                    bus_sel = tiny16_bus_pkg::ALU;
                    wr_hi   = 1'b1;
                    wr_lo   = 1'b1;
                    flag_en = 1'b1;
                end
                tiny16_isa_pkg::LDI: begin
                    ctl_data = imm_lo;
                    bus_sel  = tiny16_bus_pkg::CTL;
                    wr_hi    = 1'b1;
                    wr_lo    = 1'b1;
                end
                tiny16_isa_pkg::LUI: begin
                    ctl_data = {ir.operand.imm_form.imm, 8'h00};
                    bus_sel  = tiny16_bus_pkg::CTL;
                    wr_hi    = 1'b1;
                end
                tiny16_isa_pkg::LD: begin
                    bus_sel = tiny16_bus_pkg::MEM;
                    wr_hi   = 1'b1;
                    wr_lo   = 1'b1;
                end
                tiny16_isa_pkg::JMP, tiny16_isa_pkg::JZ, tiny16_isa_pkg::JNZ: begin
                    ctl_data = imm_lo;
                    bus_sel  = tiny16_bus_pkg::CTL;
                    case (ir.opcode)
                        tiny16_isa_pkg::JZ:  pc_load = flags.z;
                        tiny16_isa_pkg::JNZ: pc_load = !flags.z;
                        default:             pc_load = 1'b1;
                    endcase
                end
                tiny16_isa_pkg::IN: begin
                    bus_sel = tiny16_bus_pkg::INPORT;
                    wr_hi   = 1'b1;
                    wr_lo   = 1'b1;
                end
                tiny16_isa_pkg::OUT: begin
                    bus_sel = tiny16_bus_pkg::REG;
                    out_en  = 1'b1;
                end
                default: ;  // ST done in MEM, HALT handled by the FSM
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/data_bus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tiny16_consts.svh"

module data_bus (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire tiny16_bus_pkg::bus_src_e src,
    input  wire  [`TINY16_XLEN-1:0] reg_data,
    input  wire  [`TINY16_XLEN-1:0] alu_data,
    input  wire  [`TINY16_XLEN-1:0] mem_data,
    input  wire  [`TINY16_XLEN-1:0] ctl_data,
    input  wire  [7:0]              in_port,
    input  wire                     out_en,
    output logic [`TINY16_XLEN-1:0] bus,
    output logic [7:0]              out_port,
    output logic                    out_strobe
);

    logic [`TINY16_XLEN-1:0] bus_q;  // last value actually driven
    logic [7:0]              in_meta;
    logic [7:0]              in_sync;

    // one driver per cycle
    always_comb begin
        unique case (src)
            tiny16_bus_pkg::REG:    bus = reg_data;
            tiny16_bus_pkg::ALU:    bus = alu_data;
            tiny16_bus_pkg::MEM:    bus = mem_data;
            tiny16_bus_pkg::CTL:    bus = ctl_data;
            tiny16_bus_pkg::INPORT: bus = {{(`TINY16_XLEN-8){1'b0}}, in_sync};
            default:                bus = bus_q;  // nobody drives, hold
        endcase
    end

    always_ff @(posedge clk) begin
        if (src != tiny16_bus_pkg::NONE) begin
            bus_q <= bus;
        end
    end

    // input port is asynchronous to the core, two flops
    always_ff @(posedge clk) begin
        in_meta <= in_port;
        in_sync <= in_meta;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_port   <= `TINY16_OUT_RESET;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= out_en;  // high in the cycle the new byte shows
            if (out_en) begin
                out_port <= bus[7:0];
            end
        end
    end

endmodule

`default_nettype wire

/* design/registers.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tiny16_consts.svh"

module registers (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire  [3:0]              src_sel,
    input  wire  [3:0]              dst_sel,
    input  wire                     wr_hi,
    input  wire                     wr_lo,
    input  wire                     pc_inc,
    input  wire                     pc_load,
    input  wire  [`TINY16_XLEN-1:0] bus_in,
    output logic [`TINY16_XLEN-1:0] src,
    output logic [`TINY16_XLEN-1:0] dst,
    output logic [`TINY16_XLEN-1:0] pc
);

    logic [`TINY16_XLEN-1:0] regs [`TINY16_NREGS];

    // byte lanes written separately, LUI only touches the upper one
    always_ff @(posedge clk) begin
        if (wr_hi) begin
            regs[dst_sel][`TINY16_XLEN-1:`TINY16_XLEN/2] <= bus_in[`TINY16_XLEN-1:`TINY16_XLEN/2];
        end
        if (wr_lo) begin
            regs[dst_sel][`TINY16_XLEN/2-1:0] <= bus_in[`TINY16_XLEN/2-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `TINY16_RESET_PC;
        end else if (pc_load) begin
            pc <= bus_in;  // jump target from the bus
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // both read ports are asynchronous
    assign src = regs[src_sel];
    assign dst = regs[dst_sel];

endmodule

`default_nettype wire

/* design/tiny16.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tiny16_consts.svh"

module tiny16 (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [7:0]                   in_port,
    output wire  [7:0]                   out_port,
    output wire                          out_strobe,
    output wire                          halted,
    output wire tiny16_bus_pkg::wb_req_t wb_req,
    input  wire tiny16_bus_pkg::wb_rsp_t wb_rsp
);

    wire [3:0]                  src_sel;
    wire [3:0]                  dst_sel;
    wire                        wr_hi;
    wire                        wr_lo;
    wire                        pc_inc;
    wire                        pc_load;
    wire [`TINY16_XLEN-1:0]     bus;       // shared internal bus
    wire [`TINY16_XLEN-1:0]     src_data;
    wire [`TINY16_XLEN-1:0]     dst_data;
    wire [`TINY16_XLEN-1:0]     pc;
    wire tiny16_isa_pkg::alu_func_e alu_func;
    wire                        flag_en;
    wire [`TINY16_XLEN-1:0]     alu_result;
    wire tiny16_isa_pkg::flags_t flags;
    wire tiny16_bus_pkg::bus_src_e bus_sel;
    wire [`TINY16_XLEN-1:0]     ctl_data;
    wire [`TINY16_XLEN-1:0]     mem_data;
    wire                        out_en;

    registers regs (
        .clk(clk), .rst_n(rst_n),
        .src_sel(src_sel), .dst_sel(dst_sel),
        .wr_hi(wr_hi), .wr_lo(wr_lo),
        .pc_inc(pc_inc), .pc_load(pc_load),
        .bus_in(bus),
        .src(src_data), .dst(dst_data), .pc(pc)
    );

    // dst is the left operand, as in rd = rd op rs
    alu arith (
        .clk(clk), .rst_n(rst_n),
        .func(alu_func),
        .op_a(dst_data), .op_b(src_data),
        .flag_en(flag_en),
        .result(alu_result), .flags(flags)
    );

    data_bus bs (
        .clk(clk), .rst_n(rst_n),
        .src(bus_sel),
        .reg_data(src_data), .alu_data(alu_result),
        .mem_data(mem_data), .ctl_data(ctl_data),
        .in_port(in_port), .out_en(out_en),
        .bus(bus), .out_port(out_port), .out_strobe(out_strobe)
    );

    controller ctrl (
        .clk(clk), .rst_n(rst_n),
        .bus(bus), .flags(flags), .pc(pc),
        .dst_data(dst_data), .src_data(src_data),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .src_sel(src_sel), .dst_sel(dst_sel),
        .wr_hi(wr_hi), .wr_lo(wr_lo),
        .pc_inc(pc_inc), .pc_load(pc_load),
        .alu_func(alu_func), .flag_en(flag_en),
        .bus_sel(bus_sel), .ctl_data(ctl_data), .mem_data(mem_data),
        .out_en(out_en), .halted(halted)
    );

endmodule

`default_nettype wire

/* design/tiny16_bus_pkg.sv */
`default_nettype none

`include "tiny16_consts.svh"

package tiny16_bus_pkg;

    // wishbone classic master outputs
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`TINY16_XLEN-1:0] adr;
        logic [`TINY16_XLEN-1:0] dat;  // write data, only for stores
    } wb_req_t;

    // slave response, no err or retry
    typedef struct packed {
        logic                    ack;
        logic [`TINY16_XLEN-1:0] dat;
    } wb_rsp_t;

    // which block drives the internal bus this cycle
    typedef enum logic [2:0] {
        NONE   = 3'd0,  // bus holds its last value
        REG    = 3'd1,
        ALU    = 3'd2,
        MEM    = 3'd3,
        CTL    = 3'd4,
        INPORT = 3'd5
    } bus_src_e;

endpackage

`default_nettype wire

/* design/tiny16_consts.svh */
`ifndef TINY16_CONSTS_SVH
`define TINY16_CONSTS_SVH

// data path and address width, one word
`define TINY16_XLEN 16

// general registers, indexed by the 4-bit fields of the encoding
`define TINY16_NREGS 16

// first fetch address after reset
`define TINY16_RESET_PC 16'h0000

// output port value after reset
`define TINY16_OUT_RESET 8'h55

`endif

/* design/tiny16_isa_pkg.sv */
`default_nettype none

package tiny16_isa_pkg;

    // top nibble of every instruction word
    typedef enum logic [3:0] {
        ALU  = 4'h0,  // rd = rd func rs
        LDI  = 4'h1,  // rd = {00, imm}
        LUI  = 4'h2,  // rd[15:8] = imm, low byte kept
        LD   = 4'h3,  // rd = mem[rs]
        ST   = 4'h4,  // mem[rd] = rs
        JMP  = 4'h5,  // pc = imm
        JZ   = 4'h6,
        JNZ  = 4'h7,
        IN   = 4'h8,  // rd = {00, in_port}
        OUT  = 4'h9,  // out_port = rs[7:0]
        HALT = 4'hA
    } opcode_e;

    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        OR  = 4'h3,
        XOR = 4'h4,
        SHL = 4'h5,  // rs shifted left by one
        SHR = 4'h6,  // rs shifted right by one
        MOV = 4'h7
    } alu_func_e;

    typedef struct packed {
        logic [3:0] dst;
        logic [3:0] src;
        alu_func_e  alu_func;
    } reg_form_t;

    typedef struct packed {
        logic [3:0] dst;
        logic [7:0] imm;
    } imm_form_t;

    // low 12 bits, read either way depending on the opcode
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } operand_u;

    typedef struct packed {
        opcode_e  opcode;
        operand_u operand;
    } instr_t;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flags_t;

endpackage

`default_nettype wire

/* tiny16.f */
+incdir+design
design/tiny16_isa_pkg.sv
design/tiny16_bus_pkg.sv
design/registers.sv
design/alu.sv
design/data_bus.sv
design/controller.sv
design/tiny16.sv
verification/tb_clock.sv
verification/tiny16_assertions.sv
verification/tb_tiny16.sv

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// free running clock for the testbench, 100 ns period
module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

/* verification/tb_tiny16.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tiny16_consts.svh"

module tb_tiny16;

    localparam time DRIVE_DELAY    = 10;    // after the rising edge
    localparam int  STIM_WORDS     = 256;
    localparam int  MEM_WORDS      = 256;
    localparam int  CYCLES_PER_TEST = 2000;
    localparam int  RESET_CYCLES   = 4;
    localparam int  HALT_CYCLES    = 8;     // watched after halted rises

    wire                          clk;
    logic                         rst_n = 1'b0;
    logic [7:0]                   in_port = 8'h00;
    wire  [7:0]                   out_port;
    wire                          out_strobe;
    wire                          halted;
    wire tiny16_bus_pkg::wb_req_t wb_req;
    tiny16_bus_pkg::wb_rsp_t      wb_rsp = '0;

    logic [15:0] mem [MEM_WORDS];
    logic [15:0] stim [STIM_WORDS];
    logic [7:0]  outs [$];
    int unsigned pos;
    int unsigned ntests = 0;
    logic        stim_ready = 1'b0;

    tb_clock clk_gen (.clk(clk));

    tiny16 dut (
        .clk(clk), .rst_n(rst_n),
        .in_port(in_port), .out_port(out_port), .out_strobe(out_strobe),
        .halted(halted), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    bind tiny16 tiny16_assertions asserts (
        .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .out_port(out_port), .out_strobe(out_strobe), .halted(halted)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compare(input string name, input logic [15:0] got,
                           input logic [15:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic read_word(output logic [15:0] w);
        if (pos >= STIM_WORDS || $isunknown(stim[pos])) begin
            abort_run("stimulus file ended in the middle of a test");
        end else begin
            w = stim[pos];
            pos++;
        end
    endtask

    task automatic check_reset_state();
        compare("out_port", out_port, `TINY16_OUT_RESET);
        compare("out_strobe", out_strobe, 1'b0);
        compare("halted", halted, 1'b0);
    endtask

    // wishbone slave with 0 to 3 random wait states per request
    task automatic serve_bus();
        int unsigned wait_left;
        logic        busy;
        wait_left = 0;
        busy      = 1'b0;
        forever begin
            wait_cycle();
            if (wb_rsp.ack) begin
                wb_rsp.ack = 1'b0;  // ack lasts one cycle
                busy       = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    if (wb_req.we) begin
                        mem[wb_req.adr[7:0]] = wb_req.dat;
                    end else begin
                        wb_rsp.dat = mem[wb_req.adr[7:0]];
                    end
                    wb_rsp.ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    endtask

    task automatic run_one_test(input int t);
        logic [15:0] word;
        logic [15:0] count;
        logic [15:0] addr;
        logic [15:0] expected;
        rst_n = 1'b0;
        read_word(word);
        in_port = word[7:0];
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = {~a[7:0], a[7:0]};
        end
        read_word(count);
        for (int i = 0; i < count; i++) begin
            read_word(mem[i]);
        end
        repeat (RESET_CYCLES) wait_cycle();
        check_reset_state();
        rst_n = 1'b1;
        wait_cycle();
        check_reset_state();

        outs.delete();
        while (!halted) begin
            wait_cycle();
            if (out_strobe) begin
                outs.push_back(out_port);
            end
        end
        repeat (HALT_CYCLES) begin
            wait_cycle();
            compare("halted", halted, 1'b1);
            compare("wb_req.cyc", wb_req.cyc, 1'b0);
        end

        read_word(count);
        compare($sformatf("test %0d out_port byte count", t), outs.size(), count);
        for (int i = 0; i < count; i++) begin
            read_word(expected);
            compare($sformatf("test %0d out_port byte %0d", t, i), outs[i], expected);
        end
        read_word(count);  // stores left in memory
        for (int i = 0; i < count; i++) begin
            read_word(addr);
            read_word(expected);
            compare($sformatf("test %0d mem[%02h]", t, addr[7:0]), mem[addr[7:0]], expected);
        end
    endtask

    initial begin : run_tests
        void'($urandom(32'h8553_6658));
        $readmemh("verification/tiny16_stimulus.txt", stim);
        if ($isunknown(stim[0]) || stim[0] == 16'h0000) begin
            abort_run("no tests found in verification/tiny16_stimulus.txt");
        end else begin
            ntests     = stim[0];
            pos        = 1;
            stim_ready = 1'b1;
            fork
                serve_bus();
            join_none
            for (int t = 0; t < ntests; t++) begin
                run_one_test(t);
            end
            if (dut.asserts.violations == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

    initial begin : assertion_monitor
        wait (dut.asserts.violations != 0);
        abort_run("a bound wishbone or reset assertion on the DUT failed");
    end

    initial begin : watchdog
        wait (stim_ready);
        repeat (ntests * CYCLES_PER_TEST) @(posedge clk);
        abort_run($sformatf("timeout, tests did not finish within %0d cycles",
                            ntests * CYCLES_PER_TEST));
    end

endmodule

`default_nettype wire

/* verification/tiny16_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tiny16_consts.svh"

module tiny16_assertions (
    input wire                          clk,
    input wire                          rst_n,
    input wire tiny16_bus_pkg::wb_req_t wb_req,
    input wire tiny16_bus_pkg::wb_rsp_t wb_rsp,
    input wire  [7:0]                   out_port,
    input wire                          out_strobe,
    input wire                          halted
);

    int unsigned violations = 0;  // failed assertion count

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc)
        else begin
            violations++;
            $error("wishbone stb high without cyc");
        end

    // request must not move until the slave acks it
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=>
            (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat)))
        else begin
            violations++;
            $error("wishbone request changed while waiting for ack");
        end

    no_cyc_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !wb_req.cyc)
        else begin
            violations++;
            $error("bus cycle started while halted");
        end

    reset_state: assert property (@(posedge clk)
        !rst_n |=> (out_port == `TINY16_OUT_RESET && !out_strobe && !halted &&
                    !wb_req.cyc && !wb_req.stb && !wb_req.we))
        else begin
            violations++;
            $error("outputs not at their reset values");
        end

endmodule

`default_nettype wire

/* verification/tiny16_stimulus.txt */
// hex words: test count, then for each test
// in_port, program length, program words, output count, output bytes, store count, address/value pairs
04
// alu functions, ldi and lui
00 1C
113C 120F 2212 0317 0320 9030 0417 0421 9040 0517 0522 9050 0617 0623
9060 0717 0724 9070 0815 9080 0916 9090 9020 1A80 2A01 0BA6 90B0 A000
09 4B 2D 0C 3F 33 78 1E 0F C0
00
// store then load back through memory
00 0F
1180 12A5 22C3 4120 1381 145A 4340 3510 3630 9060 0560 9050 1782 4750 A000
02 5A FF
03 0080 C3A5 0081 005A 0082 C3FF
// jnz countdown, jz taken and not taken, jmp loop
00 10
1103 1201 9010 0121 7002 6008 14EE 9040 1502 9050 0521 600D 5009 16AA 9060 A000
06 03 02 01 02 01 AA
00
// input port read back and incremented
96 06
8100 9010 1201 0120 9010 A000
02 96 97
00
